// ==== Bender.yml ====
package:
  name: ppm_uart_io

sources:
  - include_dirs:
      - source
    files:
      - source/ppm_uart_io_pkg.sv
      - source/uart_rx.sv
      - source/uart_tx.sv
      - source/program_loader.sv
      - source/pixel_digits.sv
      - source/ppm_sender.sv
      - source/ppm_uart_io.sv
  - target: verif
    include_dirs:
      - source
    files:
      - verif/tb_ppm_uart_io.sv

// ==== ppm_uart_io.f ====
+incdir+source
source/ppm_uart_io_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/program_loader.sv
source/pixel_digits.sv
source/ppm_sender.sv
source/ppm_uart_io.sv
verif/tb_ppm_uart_io.sv

// ==== source/pixel_digits.sv ====
`timescale 1ns/100ps

module pixel_digits import ppm_uart_io_pkg::*; (
  input  logic     clk,
  input  logic     rstn,
  input  logic     in_valid,
  input  rgb_t     pixel,
  output logic     out_valid,
  output rgb_dec_t digits
);

  logic [2:0][7:0]  chan;
  logic [2:0][3:0]  hund_d;
  logic [2:0][6:0]  rem100_d;
  logic [2:0][3:0]  tens_d;
  logic [2:0][3:0]  rem10_d;
  logic [2:0][3:0]  s1_hund_q;
  logic [2:0][6:0]  s1_rem_q;
  logic [2:0][3:0]  s2_hund_q;
  logic [2:0][3:0]  s2_tens_q;
  logic [2:0][3:0]  s2_ones_q;
  logic [2:0][11:0] s3_q;
  logic [2:0]       valid_q;

  function automatic logic digits_ok(input rgb_dec_t d);
    for (int i = 0; i < 9; i++) begin
      if (d[i*4 +: 4] > 4'd9) return 1'b0;
    end
    return 1'b1;
  endfunction

  assign chan      = pixel; // r in [2], b in [0]
  assign digits    = s3_q;
  assign out_valid = valid_q[2];

  always_comb begin
    for (int c = 0; c < 3; c++) begin
      if (chan[c] >= 8'd200) begin
        hund_d[c]   = 4'd2;
        rem100_d[c] = 7'(chan[c] - 8'd200);
      end else if (chan[c] >= 8'd100) begin
        hund_d[c]   = 4'd1;
        rem100_d[c] = 7'(chan[c] - 8'd100);
      end else begin
        hund_d[c]   = 4'd0;
        rem100_d[c] = chan[c][6:0];
      end
    end
  end

  always_comb begin
    for (int c = 0; c < 3; c++) begin
      tens_d[c]  = 4'd0;
      rem10_d[c] = s1_rem_q[c][3:0];
      for (int k = 1; k < 10; k++) begin
        if (s1_rem_q[c] >= 7'(10 * k)) begin // highest multiple wins
          tens_d[c]  = 4'(k);
          rem10_d[c] = 4'(s1_rem_q[c] - 7'(10 * k));
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    s1_hund_q <= hund_d;
    s1_rem_q  <= rem100_d;
    s2_hund_q <= s1_hund_q;
    s2_tens_q <= tens_d;
    s2_ones_q <= rem10_d;
    for (int c = 0; c < 3; c++) s3_q[c] <= {s2_hund_q[c], s2_tens_q[c], s2_ones_q[c]};
  end

  always_ff @(posedge clk) begin
    if (!rstn) valid_q <= '0;
    else valid_q <= {valid_q[1:0], in_valid};
  end

  a_digit_range: assert property (@(posedge clk) disable iff (!rstn)
    out_valid |-> digits_ok(digits));

endmodule

// ==== source/ppm_sender.sv ====
`timescale 1ns/100ps
`include "ppm_uart_io_consts.svh"

module ppm_sender import ppm_uart_io_pkg::*; #(
  parameter int img_width  = `PPM_IMG_WIDTH,
  parameter int img_height = `PPM_IMG_HEIGHT
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     core_start,
  input  logic     core_end,
  input  logic     tx_busy,
  input  wb_rsp_t  dmem_rsp,
  input  logic     digits_valid,
  input  rgb_dec_t digits,
  output tx_req_t  tx_req,
  output wb_req_t  dmem_req,
  output logic     pixel_valid,
  output rgb_t     pixel
);

  localparam int num_pixels = img_width * img_height;
  localparam int pix_w = $clog2(num_pixels + 1);

  function automatic logic [23:0] dec_ascii(input int unsigned v);
    return {`PPM_ASCII_ZERO + 8'(v / 100 % 10), `PPM_ASCII_ZERO + 8'(v / 10 % 10),
            `PPM_ASCII_ZERO + 8'(v % 10)};
  endfunction

  // "P3\n" www hhh 255, first byte in the top bits
  localparam logic [119:0] header = {`PPM_ASCII_P, `PPM_ASCII_ZERO + 8'd3, `PPM_ASCII_NEWLINE,
    dec_ascii(img_width), `PPM_ASCII_SPACE, dec_ascii(img_height), `PPM_ASCII_SPACE,
    `PPM_MAX_VALUE_DIGITS, `PPM_ASCII_NEWLINE};

  typedef enum logic [3:0] {
    st_greet, st_wait_load, st_done, st_wait_end, st_header,
    st_read, st_convert, st_pixel, st_finish
  } send_state_t;

  send_state_t      state_q;
  logic [3:0]       step_q;
  logic [pix_w-1:0] pix_q;
  logic             loaded_q;
  logic             cyc_q;
  logic             tx_valid_q;
  logic [7:0]       tx_data_q;
  rgb_dec_t         digits_q;
  logic [3:0]       digit_sel;
  logic [7:0]       pixel_byte;
  logic [7:0]       send_byte;
  logic             sending;
  logic             accept;

  assign accept      = tx_valid_q && !tx_busy;
  assign tx_req      = '{valid: tx_valid_q, data: tx_data_q};
  assign pixel_valid = cyc_q && dmem_rsp.ack;
  assign pixel       = '{r: dmem_rsp.dat[7:0], g: dmem_rsp.dat[15:8], b: dmem_rsp.dat[23:16]};
  assign dmem_req    = '{
    cyc: cyc_q,
    stb: cyc_q,
    we:  1'b0,
    adr: `PPM_DATA_BASE + 32'({pix_q, 2'b00}),
    dat: '0
  };

  always_comb begin
    digit_sel = 4'(step_q[3:2]) * 4'd3 + 4'(step_q[1:0]); // r.h first, b.o last
    if (step_q[1:0] != 2'd3) pixel_byte = `PPM_ASCII_ZERO + 8'(digits_q[4 * (8 - int'(digit_sel)) +: 4]);
    else if (step_q[3:2] == 2'd2) pixel_byte = `PPM_ASCII_NEWLINE;
    else pixel_byte = `PPM_ASCII_SPACE;
  end

  always_comb begin
    sending   = 1'b1;
    send_byte = pixel_byte;
    unique case (state_q)
      st_greet:  send_byte = `PPM_GREETING_BYTE;
      st_done:   send_byte = `PPM_LOADED_BYTE;
      st_header: send_byte = header[8 * (14 - int'(step_q)) +: 8];
      st_pixel:  send_byte = pixel_byte;
      default:   sending = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sending && !tx_valid_q) tx_data_q <= send_byte;
    if (digits_valid) digits_q <= digits;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q    <= st_greet;
      step_q     <= '0;
      pix_q      <= '0;
      loaded_q   <= 1'b0;
      cyc_q      <= 1'b0;
      tx_valid_q <= 1'b0;
    end else begin
      if (core_start) loaded_q <= 1'b1;
      if (sending && !tx_valid_q) tx_valid_q <= 1'b1;
      if (accept) tx_valid_q <= 1'b0;
      unique case (state_q)
        st_greet:     if (accept) state_q <= st_wait_load;
        st_wait_load: if (loaded_q) state_q <= st_done;
        st_done:      if (accept) state_q <= st_wait_end;
        st_wait_end:  if (core_end) state_q <= st_header;
        st_header: if (accept) begin
          step_q <= step_q + 4'd1;
          if (step_q == 4'd14) begin
            step_q  <= '0;
            state_q <= st_read;
            cyc_q   <= 1'b1;
          end
        end
        st_read: if (cyc_q && dmem_rsp.ack) begin
          cyc_q   <= 1'b0;
          state_q <= st_convert;
        end
        st_convert: if (digits_valid) state_q <= st_pixel;
        st_pixel: if (accept) begin
          step_q <= step_q + 4'd1;
          if (step_q == 4'd11) begin // newline gone, next pixel
            step_q <= '0;
            if (pix_q == pix_w'(num_pixels - 1)) begin
              state_q <= st_finish;
            end else begin
              pix_q   <= pix_q + pix_w'(1);
              state_q <= st_read;
              cyc_q   <= 1'b1;
            end
          end
        end
        default: ;
      endcase
    end
  end

  a_wb_hold: assert property (@(posedge clk) disable iff (!rstn)
    dmem_req.stb && !dmem_rsp.ack |=> dmem_req.stb && dmem_req.cyc && $stable(dmem_req.adr));

endmodule

// ==== source/ppm_uart_io.sv ====
`timescale 1ns/100ps
`include "ppm_uart_io_consts.svh"

module ppm_uart_io import ppm_uart_io_pkg::*; #(
  parameter int clks_per_bit = `PPM_CLKS_PER_BIT,
  parameter int img_width    = `PPM_IMG_WIDTH,
  parameter int img_height   = `PPM_IMG_HEIGHT
) (
  input  logic    clk,
  input  logic    rstn,
  input  logic    rxd,
  output logic    txd,
  output wb_req_t imem_req,
  input  wb_rsp_t imem_rsp,
  output wb_req_t dmem_req,
  input  wb_rsp_t dmem_rsp,
  output logic    core_start,
  input  logic    core_end
);

  uart_byte_t rx_byte;
  tx_req_t    tx_req;
  logic       tx_busy;
  logic       pixel_valid;
  rgb_t       pixel;
  logic       digits_valid;
  rgb_dec_t   digits;

  uart_rx #(
    .clks_per_bit(clks_per_bit)
  ) u_uart_rx (
    .clk (clk),
    .rstn(rstn),
    .rxd (rxd),
    .rx  (rx_byte)
  );

  program_loader u_program_loader (
    .clk       (clk),
    .rstn      (rstn),
    .rx        (rx_byte),
    .imem_rsp  (imem_rsp),
    .imem_req  (imem_req),
    .core_start(core_start)
  );

  pixel_digits u_pixel_digits (
    .clk      (clk),
    .rstn     (rstn),
    .in_valid (pixel_valid),
    .pixel    (pixel),
    .out_valid(digits_valid),
    .digits   (digits)
  );

  ppm_sender #(
    .img_width (img_width),
    .img_height(img_height)
  ) u_ppm_sender (
    .clk         (clk),
    .rstn        (rstn),
    .core_start  (core_start),
    .core_end    (core_end),
    .tx_busy     (tx_busy),
    .dmem_rsp    (dmem_rsp),
    .digits_valid(digits_valid),
    .digits      (digits),
    .tx_req      (tx_req),
    .dmem_req    (dmem_req),
    .pixel_valid (pixel_valid),
    .pixel       (pixel)
  );

  uart_tx #(
    .clks_per_bit(clks_per_bit)
  ) u_uart_tx (
    .clk (clk),
    .rstn(rstn),
    .req (tx_req),
    .busy(tx_busy),
    .txd (txd)
  );

endmodule

// ==== source/ppm_uart_io_consts.svh ====
`ifndef PPM_UART_IO_CONSTS_SVH
`define PPM_UART_IO_CONSTS_SVH

// handshake bytes towards the host
`define PPM_GREETING_BYTE 8'h99
`define PPM_LOADED_BYTE   8'haa

// ascii
`define PPM_ASCII_ZERO    8'h30
`define PPM_ASCII_P       8'h50
`define PPM_ASCII_SPACE   8'h20
`define PPM_ASCII_NEWLINE 8'h0a

// 50 MHz clock at 115200 baud
`define PPM_CLKS_PER_BIT 434

// image geometry
`define PPM_IMG_WIDTH  128
`define PPM_IMG_HEIGHT 128

// colour range, sent as text
`define PPM_MAX_VALUE_DIGITS "255"

// byte address of pixel 0 in data memory
`define PPM_DATA_BASE 32'h0000_0000

`endif

// ==== source/ppm_uart_io_pkg.sv ====
package ppm_uart_io_pkg;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } uart_byte_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } tx_req_t;

  // wishbone classic, master to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
  } wb_req_t;

  // wishbone classic, slave to master
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  typedef struct packed {
    logic [3:0] hundreds;
    logic [3:0] tens;
    logic [3:0] ones;
  } dec3_t;

  typedef struct packed {
    dec3_t r;
    dec3_t g;
    dec3_t b;
  } rgb_dec_t;

endpackage

// ==== source/program_loader.sv ====
`timescale 1ns/100ps

module program_loader import ppm_uart_io_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  uart_byte_t rx,
  input  wb_rsp_t    imem_rsp,
  output wb_req_t    imem_req,
  output logic       core_start
);

  logic [31:0] asm_q;
  logic [31:0] word;
  logic [1:0]  byte_idx_q;
  logic        have_len_q;
  logic [29:0] words_left_q;
  logic [29:0] wr_idx_q;
  logic [31:0] wr_dat_q;
  logic        cyc_q;
  logic        take;
  logic        word_done;

  assign word = {rx.data, asm_q[31:8]}; // first byte ends up lowest
  assign take = rx.valid && !(have_len_q && words_left_q == '0);
  assign word_done = take && byte_idx_q == 2'd3;

  assign imem_req = '{
    cyc: cyc_q,
    stb: cyc_q,
    we:  1'b1,
    adr: {wr_idx_q, 2'b00},
    dat: wr_dat_q
  };

  always_ff @(posedge clk) begin
    if (take) asm_q <= word;
    if (word_done && have_len_q) wr_dat_q <= word;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      byte_idx_q   <= '0;
      have_len_q   <= 1'b0;
      words_left_q <= '0;
      wr_idx_q     <= '0;
      cyc_q        <= 1'b0;
      core_start   <= 1'b0;
    end else begin
      core_start <= 1'b0;
      if (take) byte_idx_q <= byte_idx_q + 2'd1;
      if (word_done && !have_len_q) begin
        have_len_q   <= 1'b1;
        words_left_q <= word[31:2]; // low two bits of the byte count dropped
        if (word[31:2] == '0) core_start <= 1'b1;
      end else if (word_done) begin
        words_left_q <= words_left_q - 30'd1;
        cyc_q        <= 1'b1;
      end
      if (cyc_q && imem_rsp.ack) begin
        cyc_q    <= 1'b0;
        wr_idx_q <= wr_idx_q + 30'd1;
        if (words_left_q == '0) core_start <= 1'b1; // that was the last word
      end
    end
  end

  a_wb_hold: assert property (@(posedge clk) disable iff (!rstn)
    imem_req.stb && !imem_rsp.ack |=>
      imem_req.stb && imem_req.cyc && $stable(imem_req.adr) && $stable(imem_req.dat));

endmodule

// ==== source/uart_rx.sv ====
`timescale 1ns/100ps
`include "ppm_uart_io_consts.svh"

module uart_rx import ppm_uart_io_pkg::*; #(
  parameter int clks_per_bit = `PPM_CLKS_PER_BIT
) (
  input  logic       clk,
  input  logic       rstn,
  input  logic       rxd,
  output uart_byte_t rx
);

  localparam int cnt_w = $clog2(clks_per_bit + 1);

  typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

  rx_state_t        state_q;
  logic [cnt_w-1:0] cnt_q;
  logic [2:0]       bit_q;
  logic [7:0]       shift_q;
  logic             rxd_meta_q;
  logic             rxd_sync_q;
  logic             rxd_prev_q;
  logic             valid_q;
  logic             half_hit;
  logic             full_hit;

  assign half_hit = cnt_q == cnt_w'(clks_per_bit / 2 - 1);
  assign full_hit = cnt_q == cnt_w'(clks_per_bit - 1);
  assign rx = '{valid: valid_q, data: shift_q};

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rxd_meta_q <= 1'b1;
      rxd_sync_q <= 1'b1;
      rxd_prev_q <= 1'b1;
    end else begin
      rxd_meta_q <= rxd;
      rxd_sync_q <= rxd_meta_q;
      rxd_prev_q <= rxd_sync_q;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == rx_data && full_hit) shift_q <= {rxd_sync_q, shift_q[7:1]}; // lsb first
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q <= rx_idle;
      cnt_q   <= '0;
      bit_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      cnt_q   <= cnt_q + cnt_w'(1);
      unique case (state_q)
        rx_idle: begin
          cnt_q <= '0;
          if (rxd_prev_q && !rxd_sync_q) state_q <= rx_start; // falling edge
        end
        rx_start: if (half_hit) begin
          cnt_q   <= '0;
          bit_q   <= '0;
          state_q <= rxd_sync_q ? rx_idle : rx_data; // glitch, not a start bit
        end
        rx_data: if (full_hit) begin
          cnt_q <= '0;
          bit_q <= bit_q + 3'd1;
          if (bit_q == 3'd7) state_q <= rx_stop;
        end
        rx_stop: if (full_hit) begin
          valid_q <= rxd_sync_q; // bad stop bit drops the byte
          state_q <= rx_idle;
        end
      endcase
    end
  end

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/100ps
`include "ppm_uart_io_consts.svh"

module uart_tx import ppm_uart_io_pkg::*; #(
  parameter int clks_per_bit = `PPM_CLKS_PER_BIT
) (
  input  logic    clk,
  input  logic    rstn,
  input  tx_req_t req,
  output logic    busy,
  output logic    txd
);

  localparam int cnt_w = $clog2(clks_per_bit + 1);

  logic [cnt_w-1:0] cnt_q;
  logic [3:0]       bit_q;
  logic [8:0]       shift_q;
  logic             busy_q;
  logic             txd_q;
  logic             accept;
  logic             bit_end;

  assign accept  = req.valid && !busy_q;
  assign bit_end = cnt_q == cnt_w'(clks_per_bit - 1);
  assign busy    = busy_q;
  assign txd     = txd_q;

  always_ff @(posedge clk) begin
    if (accept) shift_q <= {1'b1, req.data}; // stop bit rides above the data
    else if (busy_q && bit_end) shift_q <= {1'b1, shift_q[8:1]};
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy_q <= 1'b0;
      txd_q  <= 1'b1;
      cnt_q  <= '0;
      bit_q  <= '0;
    end else if (accept) begin
      busy_q <= 1'b1;
      txd_q  <= 1'b0; // start bit
      cnt_q  <= '0;
      bit_q  <= '0;
    end else if (busy_q) begin
      if (bit_end) begin
        cnt_q <= '0;
        if (bit_q == 4'd9) begin
          busy_q <= 1'b0;
        end else begin
          bit_q <= bit_q + 4'd1;
          txd_q <= shift_q[0];
        end
      end else begin
        cnt_q <= cnt_q + cnt_w'(1);
      end
    end
  end

  // sender keeps its byte steady until the frame in flight is done
  a_req_hold: assert property (@(posedge clk) disable iff (!rstn)
    req.valid && busy_q |=> req.valid && $stable(req.data));

endmodule

// ==== verif/tb_ppm_uart_io.sv ====
`timescale 1ns/100ps
`include "ppm_uart_io_consts.svh"

module tb_ppm_uart_io import ppm_uart_io_pkg::*; ();

  localparam int clks_per_bit    = 8;
  localparam int img_width       = 4;
  localparam int img_height      = 2;
  localparam int num_pixels      = img_width * img_height;
  localparam int ppm_bytes       = 15 + 12 * num_pixels;
  localparam int prog_bytes      = 16;
  localparam int host_bytes      = 4 + prog_bytes;
  localparam int quiet_cycles    = 2000;
  localparam int byte_cycles     = 10 * clks_per_bit;
  localparam int watchdog_cycles =
    2 * (2 + host_bytes + ppm_bytes) * byte_cycles + 2 * quiet_cycles + 1000;

  logic    clk = 1'b0;
  logic    rstn;
  logic    rxd;
  logic    txd;
  wb_req_t imem_req;
  wb_rsp_t imem_rsp;
  wb_req_t dmem_req;
  wb_rsp_t dmem_rsp;
  logic    core_start;
  logic    core_end;

  logic [31:0] lfsr_state = 32'h0a3904d7;
  logic [31:0] dmem [num_pixels];
  logic [31:0] prog_words [4];
  logic [7:0]  rx_q [$];
  logic [31:0] imem_adr_q [$];
  logic [31:0] imem_dat_q [$];
  logic [31:0] dmem_adr_q [$];
  logic        rd_armed;
  logic [1:0]  rd_wait;
  int          errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          start_pulses = 0;
  int          writes_at_start = 0;
  int          dmem_cyc_cycles = 0;
  time         start_time = 0;
  time         last_ack_time = 0;
  time         first_tx_time = 0;
  time         release_time = 0;
  bit          host_started = 1'b0;
  bit          early_flagged = 1'b0;

  always #20 clk = ~clk;

  ppm_uart_io #(
    .clks_per_bit(clks_per_bit),
    .img_width   (img_width),
    .img_height  (img_height)
  ) u_dut (
    .clk       (clk),
    .rstn      (rstn),
    .rxd       (rxd),
    .txd       (txd),
    .imem_req  (imem_req),
    .imem_rsp  (imem_rsp),
    .dmem_req  (dmem_req),
    .dmem_rsp  (dmem_rsp),
    .core_start(core_start),
    .core_end  (core_end)
  );

  // galois lfsr, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [7:0] digit_char(input int v, input int pos);
    int d;
    d = (pos == 0) ? v / 100 : (pos == 1) ? (v / 10) % 10 : v % 10;
    return `PPM_ASCII_ZERO + 8'(d);
  endfunction

  // expected ppm text, byte idx counted from the 'P'
  function automatic logic [7:0] ref_byte(input int idx);
    int         k;
    int         chan;
    logic [7:0] value;
    if (idx < 15) begin
      case (idx)
        0:       return `PPM_ASCII_P;
        1:       return `PPM_ASCII_ZERO + 8'd3;
        2, 14:   return `PPM_ASCII_NEWLINE;
        6, 10:   return `PPM_ASCII_SPACE;
        3, 4, 5: return digit_char(img_width, idx - 3);
        7, 8, 9: return digit_char(img_height, idx - 7);
        default: return digit_char(255, idx - 11);
      endcase
    end
    k = (idx - 15) % 12;
    chan = k / 4;
    value = dmem[(idx - 15) / 12][8 * chan +: 8]; // r low, b high
    if (k % 4 != 3) return digit_char(value, k % 4);
    return (chan == 2) ? `PPM_ASCII_NEWLINE : `PPM_ASCII_SPACE;
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] adr);
    logic [31:0] idx;
    idx = (adr - `PPM_DATA_BASE) >> 2;
    if (idx < num_pixels) return dmem[idx];
    return 32'hdead_beef;
  endfunction

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("Fail at %0t: %s", $time, msg);
  endtask

  task automatic close_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic host_send(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rxd <= frame[i];
      repeat (clks_per_bit) @(posedge clk);
    end
  endtask

  task automatic wait_for_bytes(input int n, input int max_cycles);
    int waited;
    waited = 0;
    while (rx_q.size() < n && waited < max_cycles) begin
      @(posedge clk);
      waited++;
    end
    if (rx_q.size() < n) begin
      errors++;
      $display("Timed out waiting for %0d bytes on txd, only %0d arrived", n, rx_q.size());
    end
  endtask

  initial begin : txd_receiver
    logic [7:0] b;
    forever begin
      @(negedge clk);
      if (rstn && txd === 1'b0) begin
        if (first_tx_time == 0) first_tx_time = $time;
        repeat (3) @(negedge clk); // middle of start bit
        for (int i = 0; i < 8; i++) begin
          repeat (clks_per_bit) @(negedge clk);
          b[i] = txd;
        end
        repeat (clks_per_bit) @(negedge clk);
        if (txd !== 1'b1) flag_mismatch("stop bit low on txd");
        else rx_q.push_back(b);
      end
    end
  end

  always @(posedge clk) begin
    if (!rstn) begin
      imem_rsp <= '0;
    end else begin
      imem_rsp.ack <= 1'b0;
      if (imem_req.cyc && imem_req.stb && !imem_rsp.ack) begin
        imem_rsp.ack <= 1'b1;
        imem_adr_q.push_back(imem_req.adr);
        imem_dat_q.push_back(imem_req.dat);
        if (!imem_req.we) flag_mismatch("read cycle on the instruction bus");
      end
      if (imem_req.cyc && imem_rsp.ack) last_ack_time = $time; // edge that sees ack
    end
  end

  always @(posedge clk) begin : dmem_model
    logic [1:0] wait_n;
    logic       respond;
    if (!rstn) begin
      dmem_rsp <= '0;
      rd_armed <= 1'b0;
      rd_wait  <= '0;
    end else begin
      respond = 1'b0;
      dmem_rsp.ack <= 1'b0;
      if (dmem_req.cyc && dmem_req.stb && !dmem_rsp.ack) begin
        if (!rd_armed) begin
          wait_n = 2'(take_bits(2)); // 0 to 3 wait states
          respond = (wait_n == 2'd0);
          rd_armed <= (wait_n != 2'd0);
          rd_wait  <= wait_n - 2'd1;
        end else if (rd_wait == 2'd0) begin
          respond = 1'b1;
          rd_armed <= 1'b0;
        end else begin
          rd_wait <= rd_wait - 2'd1;
        end
      end
      if (respond) begin
        dmem_rsp.ack <= 1'b1;
        dmem_rsp.dat <= read_word(dmem_req.adr);
        dmem_adr_q.push_back(dmem_req.adr);
        if (dmem_req.we) flag_mismatch("write cycle on the data bus");
      end
    end
  end

  always @(negedge clk) begin
    if (rstn) begin
      if (core_start) begin
        start_pulses++;
        if (start_pulses == 1) begin
          start_time = $time;
          writes_at_start = imem_adr_q.size();
        end
      end
      if (dmem_req.cyc) dmem_cyc_cycles++;
      if (!host_started && !early_flagged && (core_start || imem_req.cyc || dmem_req.cyc)) begin
        early_flagged = 1'b1;
        flag_mismatch("bus cycle or core_start before the host sent anything");
      end
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired: run did not finish within %0d cycles", watchdog_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : main_seq
    int e;
    int n_cyc;
    rstn = 1'b0;
    rxd = 1'b1;
    core_end = 1'b0;
    imem_rsp = '0;
    dmem_rsp = '0;
    for (int i = 0; i < num_pixels; i++) dmem[i] = take_bits(32);
    dmem[0][23:0] = {8'd100, 8'd255, 8'd0}; // b g r edge values
    dmem[1][23:0] = {8'd255, 8'd100, 8'd99};
    for (int i = 0; i < 4; i++) prog_words[i] = take_bits(32);

    e = errors;
    @(posedge clk);
    @(negedge clk);
    if (txd !== 1'b1 || imem_req.cyc !== 1'b0 || dmem_req.cyc !== 1'b0 || core_start !== 1'b0)
      flag_mismatch("outputs not idle during reset");
    repeat (3) @(posedge clk);
    rstn <= 1'b1;
    release_time = $time + 40;
    wait_for_bytes(1, 4 * byte_cycles);
    if (rx_q.size() > 0 && rx_q[0] !== `PPM_GREETING_BYTE)
      flag_mismatch($sformatf("greeting %h, expected %h", rx_q[0], `PPM_GREETING_BYTE));
    if (rx_q.size() > 0 && first_tx_time > release_time + 140)
      flag_mismatch("greeting start bit later than 3 cycles after reset");
    repeat (200) @(posedge clk);
    close_test("1 greeting", e);

    e = errors;
    host_started = 1'b1;
    for (int i = 0; i < 4; i++) host_send(8'(prog_bytes >> (8 * i))); // length, lsb first
    for (int w = 0; w < 4; w++) begin
      for (int b = 0; b < 4; b++) host_send(prog_words[w][8 * b +: 8]);
    end
    wait_for_bytes(2, 4 * byte_cycles);
    if (imem_adr_q.size() != 4)
      flag_mismatch($sformatf("%0d instruction writes, expected 4", imem_adr_q.size()));
    for (int i = 0; i < imem_adr_q.size(); i++) begin
      if (imem_adr_q[i] !== 32'(4 * i) || imem_dat_q[i] !== prog_words[i])
        flag_mismatch($sformatf("write %0d: %h at %h, expected %h at %h", i, imem_dat_q[i],
          imem_adr_q[i], prog_words[i], 32'(4 * i)));
    end
    if (start_pulses != 1)
      flag_mismatch($sformatf("core_start high for %0d cycles, expected 1", start_pulses));
    if (writes_at_start != 4 || start_time != last_ack_time + 20)
      flag_mismatch("core_start not in the cycle after the last write ack");
    if (rx_q.size() > 1 && rx_q[1] !== `PPM_LOADED_BYTE)
      flag_mismatch($sformatf("done byte %h, expected %h", rx_q[1], `PPM_LOADED_BYTE));
    close_test("2 program load", e);

    e = errors;
    n_cyc = dmem_cyc_cycles;
    repeat (quiet_cycles) @(posedge clk);
    if (dmem_cyc_cycles != n_cyc) flag_mismatch("data bus active before core_end");
    if (rx_q.size() != 2) flag_mismatch("bytes sent before core_end");
    close_test("3 wait for core_end", e);

    e = errors;
    core_end <= 1'b1;
    wait_for_bytes(2 + 15, 20 * byte_cycles);
    for (int i = 0; i < 15 && 2 + i < rx_q.size(); i++) begin
      if (rx_q[2 + i] !== ref_byte(i))
        flag_mismatch($sformatf("header byte %0d: %h, expected %h", i, rx_q[2 + i], ref_byte(i)));
    end
    close_test("4 ppm header", e);

    e = errors;
    wait_for_bytes(2 + ppm_bytes, (12 * num_pixels + 10) * byte_cycles);
    for (int i = 15; i < ppm_bytes && 2 + i < rx_q.size(); i++) begin
      if (rx_q[2 + i] !== ref_byte(i))
        flag_mismatch($sformatf("pixel %0d byte %0d: %h, expected %h", (i - 15) / 12,
          (i - 15) % 12, rx_q[2 + i], ref_byte(i)));
    end
    close_test("5 pixel lines", e);

    e = errors;
    n_cyc = dmem_cyc_cycles;
    repeat (quiet_cycles) @(posedge clk);
    if (dmem_adr_q.size() != num_pixels)
      flag_mismatch($sformatf("%0d data reads, expected %0d", dmem_adr_q.size(), num_pixels));
    for (int i = 0; i < dmem_adr_q.size(); i++) begin
      if (dmem_adr_q[i] !== `PPM_DATA_BASE + 32'(4 * i))
        flag_mismatch($sformatf("read %0d at %h, expected %h", i, dmem_adr_q[i],
          `PPM_DATA_BASE + 32'(4 * i)));
    end
    if (dmem_cyc_cycles != n_cyc) flag_mismatch("data bus active after the last pixel");
    if (rx_q.size() != 2 + ppm_bytes)
      flag_mismatch($sformatf("%0d bytes on txd, expected %0d", rx_q.size(), 2 + ppm_bytes));
    close_test("6 end of image", e);

    $display("tests run %0d, passed %0d, failed %0d, failed checks %0d",
      tests_passed + tests_failed, tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
